// ==== hw/attention_softmax_top.sv ====
// Dual-lane attention softmax
`default_nettype none

module attention_softmax_top #(
    parameter int COL         = 16,
    parameter int OUT_CREDITS = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_valid,
    input  wire attn_pkg::score_tile_t in_tile,
    input  wire logic                  out_credit,
    output logic                       row_credit,
    output logic                       out_valid,
    output attn_pkg::prob_tile_t       out_tile
);

    // Dispatch to lanes
    logic [1:0]                 lane_valid;
    attn_pkg::score_tile_t      lane_tile;
    // Lanes to merge and back to dispatch
    logic [1:0]                 emit_valid;
    attn_pkg::prob_tile_t [1:0] emit_tile;
    logic [1:0]                 emit_take;
    logic [1:0]                 row_done;

    softmax_dispatch_ctrl #(.COL(COL)) u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_tile    (in_tile),
        .row_done   (row_done),
        .row_credit (row_credit),
        .lane_valid (lane_valid),
        .lane_tile  (lane_tile)
    );

    // Two lanes share the registered tile, each sees its own strobe
    for (genvar k = 0; k < 2; k++) begin : g_lane
        softmax_lane #(.COL(COL)) u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .lane_valid (lane_valid[k]),
            .lane_tile  (lane_tile),
            .emit_take  (emit_take[k]),
            .emit_valid (emit_valid[k]),
            .emit_tile  (emit_tile[k]),
            .row_done   (row_done[k])
        );
    end

    softmax_merge #(.OUT_CREDITS(OUT_CREDITS)) u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .emit_valid (emit_valid),
        .emit_tile  (emit_tile),
        .out_credit (out_credit),
        .emit_take  (emit_take),
        .out_valid  (out_valid),
        .out_tile   (out_tile)
    );

endmodule

`default_nettype wire

// ==== hw/attn_pkg.sv ====
// Attention softmax shared types
`default_nettype none

package attn_pkg;

    // Scores per tile, fixed because the tile structs are sized from it
    localparam int TILE_SIZE = 4;

    // Signed attention score from the converter
    typedef logic signed [15:0] score_t;

    // Unsigned Q1.15 exponential, 16'h8000 is 1.0
    typedef logic [15:0] prob_t;

    // One input tile
    // last marks the final tile of a row
    typedef struct packed {
        logic                        last;
        score_t [TILE_SIZE-1:0]      score;
    } score_tile_t;

    // One output tile, same framing as the input
    typedef struct packed {
        logic                        last;
        prob_t [TILE_SIZE-1:0]       prob;
    } prob_tile_t;

    // Lane FSM
    // IDLE waits for a row, FILL stores it, EMIT drains exponentials
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_FILL = 2'd1,
        LANE_EMIT = 2'd2
    } lane_state_e;

endpackage

`default_nettype wire

// ==== hw/softmax_dispatch_ctrl.sv ====
// Softmax row dispatch controller
`default_nettype none

module softmax_dispatch_ctrl #(
    parameter int COL = 16
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                in_valid,
    input  wire attn_pkg::score_tile_t in_tile,
    input  wire logic [1:0]          row_done,
    output logic                     row_credit,
    output logic [1:0]               lane_valid,
    output attn_pkg::score_tile_t    lane_tile
);

    // Tiles per row and index width
    localparam int NUM_TILES = COL / attn_pkg::TILE_SIZE;
    localparam int IDX_W     = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;

    // Position of the next tile within the current row
    logic [IDX_W-1:0] tile_idx;
    // Lane that receives the current row
    logic             cur_lane;
    // Start-up credit counter, stops at 2
    logic [1:0]       init_cnt;
    logic             last_tile;

    // Row end comes from the tile count, the last flag is not trusted here
    assign last_tile = (tile_idx == IDX_W'(NUM_TILES - 1));

    // Tile routing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tile_idx   <= '0;
            cur_lane   <= 1'b0;
            lane_valid <= 2'b00;
        end else begin
            if (in_valid) begin
                // One-hot strobe to the lane owning this row
                lane_valid <= 2'b01 << cur_lane;
                if (last_tile) begin
                    tile_idx <= '0;
                    // Next row goes to the other lane
                    cur_lane <= ~cur_lane;
                end else begin
                    tile_idx <= tile_idx + 1'b1;
                end
            end else begin
                lane_valid <= 2'b00;
            end
        end
    end

    // Tile payload, registered once on its way to the lane
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_tile <= in_tile;
        end
    end

    // Row credits upstream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_cnt   <= 2'd0;
            row_credit <= 1'b0;
        end else begin
            // First two cycles after release grant one row per lane
            if (init_cnt != 2'd2) begin
                init_cnt <= init_cnt + 2'd1;
            end
            // Afterwards a freed lane returns its credit
            // merge pops one tile per cycle so at most one row_done is high
            row_credit <= (init_cnt != 2'd2) || (|row_done);
        end
    end

endmodule

`default_nettype wire

// ==== hw/softmax_lane.sv ====
// Softmax lane with row buffer and base-2 exponential
`default_nettype none

module softmax_lane #(
    parameter int COL = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  lane_valid,
    input  wire attn_pkg::score_tile_t lane_tile,
    input  wire logic                  emit_take,
    output logic                       emit_valid,
    output attn_pkg::prob_tile_t       emit_tile,
    output logic                       row_done
);

    localparam int NUM_TILES = COL / attn_pkg::TILE_SIZE;
    localparam int IDX_W     = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;

    attn_pkg::lane_state_e state;

    // Row storage, one entry per tile
    attn_pkg::score_t [attn_pkg::TILE_SIZE-1:0] row_buf [NUM_TILES];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    attn_pkg::score_t row_max;
    attn_pkg::score_t tile_max;
    attn_pkg::score_t next_max;
    logic             filling;

    // Lane accepts tiles only before emitting
    assign filling = lane_valid && (state != attn_pkg::LANE_EMIT);

    // Largest score of the incoming tile
    always_comb begin
        tile_max = lane_tile.score[0];
        for (int i = 1; i < attn_pkg::TILE_SIZE; i++) begin
            if ($signed(lane_tile.score[i]) > $signed(tile_max)) begin
                tile_max = lane_tile.score[i];
            end
        end
    end

    // Running maximum, restarts with the first tile of a row
    always_comb begin
        if (state == attn_pkg::LANE_IDLE) begin
            next_max = tile_max;
        end else if ($signed(tile_max) > $signed(row_max)) begin
            next_max = tile_max;
        end else begin
            next_max = row_max;
        end
    end

    // Row buffer and maximum
    always_ff @(posedge clk) begin
        if (filling) begin
            row_buf[wr_idx] <= lane_tile.score;
            row_max         <= next_max;
        end
    end

    // Lane FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= attn_pkg::LANE_IDLE;
            wr_idx   <= '0;
            rd_idx   <= '0;
            row_done <= 1'b0;
        end else begin
            row_done <= 1'b0;
            case (state)
                attn_pkg::LANE_IDLE, attn_pkg::LANE_FILL: begin
                    if (lane_valid) begin
                        if (wr_idx == IDX_W'(NUM_TILES - 1)) begin
                            // Whole row stored, max now final
                            wr_idx <= '0;
                            state  <= attn_pkg::LANE_EMIT;
                        end else begin
                            wr_idx <= wr_idx + 1'b1;
                            state  <= attn_pkg::LANE_FILL;
                        end
                    end
                end
                attn_pkg::LANE_EMIT: begin
                    if (emit_take) begin
                        if (rd_idx == IDX_W'(NUM_TILES - 1)) begin
                            // Last tile gone, hand the lane back
                            rd_idx   <= '0;
                            row_done <= 1'b1;
                            state    <= attn_pkg::LANE_IDLE;
                        end else begin
                            rd_idx <= rd_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= attn_pkg::LANE_IDLE;
                end
            endcase
        end
    end

    assign emit_valid = (state == attn_pkg::LANE_EMIT);

    // Exponential of the tile under the read index
    // 2^-(max - x) in Q1.15, underflows to zero at a distance of 16
    always_comb begin
        logic [16:0] diff;
        diff = '0;
        emit_tile.last = (rd_idx == IDX_W'(NUM_TILES - 1));
        for (int i = 0; i < attn_pkg::TILE_SIZE; i++) begin
            // Never negative since row_max bounds every element
            diff = 17'($signed(row_max) - $signed(row_buf[rd_idx][i]));
            if (diff >= 17'd16) begin
                emit_tile.prob[i] = 16'h0000;
            end else begin
                emit_tile.prob[i] = 16'h8000 >> diff[3:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/softmax_merge.sv ====
// Softmax lane merge with tile credits
`default_nettype none

module softmax_merge #(
    parameter int OUT_CREDITS = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [1:0]                 emit_valid,
    input  wire attn_pkg::prob_tile_t [1:0] emit_tile,
    input  wire logic                       out_credit,
    output logic [1:0]                      emit_take,
    output logic                            out_valid,
    output attn_pkg::prob_tile_t            out_tile
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    // Tile credits held from downstream
    logic [CW-1:0] credit_cnt;
    // Lane holding the oldest row
    logic          exp_lane;
    logic          take;

    // Pop only from the lane whose row is next in order
    assign take      = (credit_cnt != '0) && emit_valid[exp_lane];
    assign emit_take = {2{take}} & (2'b01 << exp_lane);

    // Credit counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({out_credit, take})
                2'b10: begin
                    // Saturate if downstream over-grants
                    if (credit_cnt != CW'(OUT_CREDITS)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                2'b01: credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Row order, flip lanes once a row has fully left
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_lane  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
            if (take && emit_tile[exp_lane].last) begin
                exp_lane <= ~exp_lane;
            end
        end
    end

    // Output tile register
    always_ff @(posedge clk) begin
        if (take) begin
            out_tile <= emit_tile[exp_lane];
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run the softmax testbench from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module attention_softmax_tb \
    -f tb.f -o attention_softmax_sim > build.log 2>&1 \
    || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/attention_softmax_sim > sim.log 2>&1
cat sim.log
grep -qx "Test completed successfully" sim.log && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

// ==== tb.f ====
hw/attn_pkg.sv
hw/softmax_dispatch_ctrl.sv
hw/softmax_lane.sv
hw/softmax_merge.sv
hw/attention_softmax_top.sv
verification/attention_softmax_tb.sv

// ==== verification/attention_softmax_tb.sv ====
// Dual-lane softmax testbench
`default_nettype none

module attention_softmax_tb;

    localparam int COL         = 16;
    localparam int OUT_CREDITS = 4;
    localparam int TPR         = COL / attn_pkg::TILE_SIZE;
    // Tiles over all tests: 1 + 4 + 2 + 3 + 20 rows
    localparam int TOTAL_TILES = 30 * TPR;
    localparam int WATCHDOG    = TOTAL_TILES * 20 + 500;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    attn_pkg::score_tile_t in_tile;
    logic                  out_credit;
    logic                  row_credit;
    logic                  out_valid;
    attn_pkg::prob_tile_t  out_tile;

    // Scoreboard state
    attn_pkg::prob_tile_t exp_q[$];
    attn_pkg::prob_tile_t got_q[$];
    attn_pkg::score_t     stim_row [COL];
    int errors        = 0;
    int checks        = 0;
    int credit_pulses = 0;
    int credits_held  = 0;
    int out_count     = 0;
    int rows_out      = 0;
    int rows_sent     = 0;
    int credit_budget = 0;
    int granted_total = 0;

    attention_softmax_top #(
        .COL         (COL),
        .OUT_CREDITS (OUT_CREDITS)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_tile    (in_tile),
        .out_credit (out_credit),
        .row_credit (row_credit),
        .out_valid  (out_valid),
        .out_tile   (out_tile)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Watchdog sized from the tile count of all tests
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped producing output", WATCHDOG);
        $display("Test failed");
        $finish;
    end

    // Monitor samples on the falling edge, away from register updates
    always @(negedge clk) begin
        if (row_credit) begin
            credit_pulses++;
            credits_held++;
            if (credits_held > 2) begin
                errors++;
                $display("Upstream holds %0d row credits, more than the two lanes", credits_held);
            end
        end
        if (out_valid) begin
            got_q.push_back(out_tile);
            out_count++;
            if (out_tile.last) begin
                rows_out++;
            end
        end
    end

    // Downstream tile credits
    // Never more outstanding than the merge can hold
    initial begin
        logic grant;
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            grant = (credit_budget > 0) && ((granted_total - out_count) < OUT_CREDITS);
            if (grant) begin
                credit_budget--;
                granted_total++;
            end
            #1;
            out_credit = grant;
        end
    end

    task automatic check_value(input string name, input logic [64:0] expected,
                               input logic [64:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One cycle, ending just after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Base-2 exponential in Q1.15, zero from a distance of 16
    function automatic attn_pkg::prob_t exp_model(input int row_max, input int x);
        int d;
        d = row_max - x;
        if (d >= 16) begin
            return 16'h0000;
        end
        return 16'(32'h8000 >> d);
    endfunction

    // Queue the model tiles and send stim_row once a row credit is held
    task automatic send_row(input bit gaps);
        int m;
        attn_pkg::prob_tile_t e;
        m = int'(stim_row[0]);
        for (int i = 1; i < COL; i++) begin
            if (int'(stim_row[i]) > m) begin
                m = int'(stim_row[i]);
            end
        end
        for (int t = 0; t < TPR; t++) begin
            e.last = (t == TPR - 1);
            for (int i = 0; i < attn_pkg::TILE_SIZE; i++) begin
                e.prob[i] = exp_model(m, int'(stim_row[t * attn_pkg::TILE_SIZE + i]));
            end
            exp_q.push_back(e);
        end
        while (credits_held == 0) begin
            step();
        end
        credits_held--;
        for (int t = 0; t < TPR; t++) begin
            in_valid     = 1'b1;
            in_tile.last = (t == TPR - 1);
            for (int i = 0; i < attn_pkg::TILE_SIZE; i++) begin
                in_tile.score[i] = stim_row[t * attn_pkg::TILE_SIZE + i];
            end
            step();
            // Optional idle cycle between tiles of one row
            if (gaps && (t != TPR - 1) && ($urandom_range(1) == 1)) begin
                in_valid = 1'b0;
                step();
            end
        end
        in_valid = 1'b0;
        rows_sent++;
    endtask

    task automatic wait_tiles(input int target, input int limit);
        int n;
        n = 0;
        while ((out_count < target) && (n < limit)) begin
            step();
            n++;
        end
        if (out_count < target) begin
            errors++;
            $display("Timed out after %0d cycles with %0d of %0d output tiles", limit,
                     out_count, target);
        end
    endtask

    // Pop both queues in order and compare tile by tile
    task automatic compare_outputs(input string name);
        attn_pkg::prob_tile_t e;
        attn_pkg::prob_tile_t g;
        while ((exp_q.size() > 0) && (got_q.size() > 0)) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            check_value(name, e, g);
        end
        if ((exp_q.size() != 0) || (got_q.size() != 0)) begin
            errors++;
            $display("%s: %0d expected tiles never arrived, %0d extra tiles arrived", name,
                     exp_q.size(), got_q.size());
            exp_q.delete();
            got_q.delete();
        end
    endtask

    task automatic reset_sequence();
        rst_n = 1'b0;
        repeat (5) begin
            step();
            check_value("reset_quiet", 2'b00, {out_valid, row_credit});
        end
        rst_n = 1'b1;
        repeat (10) step();
        // One credit per lane after release
        check_value("reset_credits", 2, credit_pulses);
        check_value("reset_held", 2, credits_held);
    endtask

    task automatic known_row();
        attn_pkg::prob_tile_t t0;
        attn_pkg::prob_tile_t t3;
        int lasts;
        // Max 100 at element 0, distance i for element i
        for (int i = 0; i < COL; i++) begin
            stim_row[i] = attn_pkg::score_t'(100 - i);
        end
        stim_row[14] = 16'sd84;
        stim_row[15] = -16'sd32768;
        credit_budget += TPR;
        send_row(1'b0);
        wait_tiles(TPR, 200);
        if (got_q.size() == TPR) begin
            t0 = got_q[0];
            t3 = got_q[TPR - 1];
            check_value("known_max", 16'h8000, t0.prob[0]);
            check_value("known_diff3", 16'h1000, t0.prob[3]);
            check_value("known_diff16", 16'h0000, t3.prob[2]);
            check_value("known_far", 16'h0000, t3.prob[3]);
            lasts = 0;
            foreach (got_q[k]) begin
                if (got_q[k].last) begin
                    lasts++;
                end
            end
            check_value("known_last_count", 1, lasts);
            check_value("known_last_pos", 1'b1, t3.last);
        end
        compare_outputs("known_row");
    endtask

    task automatic row_order();
        int base;
        base = out_count;
        credit_budget += 4 * TPR;
        // Each row gets its own spacing so a swap would show
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < COL; i++) begin
                stim_row[i] = attn_pkg::score_t'((i * (r + 1)) % 17);
            end
            send_row(1'b0);
        end
        wait_tiles(base + 4 * TPR, 400);
        compare_outputs("row_order");
    endtask

    task automatic backpressure();
        int base;
        base = out_count;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < COL; i++) begin
                stim_row[i] = attn_pkg::score_t'(r * 50 - i * 2);
            end
            send_row(1'b0);
        end
        // No tile credits, so nothing may leave
        repeat (40) step();
        check_value("bp_hold", base, out_count);
        credit_budget += 3;
        wait_tiles(base + 3, 200);
        repeat (20) step();
        check_value("bp_partial", base + 3, out_count);
        credit_budget += 2 * TPR - 3;
        wait_tiles(base + 2 * TPR, 200);
        compare_outputs("backpressure");
    endtask

    task automatic credit_return();
        int pulses;
        // Credit of the row that just left arrives two cycles after its last tile
        repeat (4) step();
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < COL; i++) begin
                stim_row[i] = attn_pkg::score_t'(-1000 + r * 7 + i);
            end
            pulses = credit_pulses;
            credit_budget += TPR;
            send_row(1'b0);
            wait_tiles(out_count - got_q.size() + exp_q.size(), 200);
            repeat (4) step();
            check_value("credit_per_row", pulses + 1, credit_pulses);
            check_value("credit_held", 2, credits_held);
        end
        compare_outputs("credit_return");
        // Two start-up credits plus one per row sent so far
        check_value("credit_rows_out", rows_sent, rows_out);
        check_value("credit_total", 2 + rows_sent, credit_pulses);
    endtask

    task automatic random_rows();
        int base;
        int v;
        base = out_count;
        credit_budget += 20 * TPR;
        for (int r = 0; r < 20; r++) begin
            // Tight cluster near a random base, with an outlier now and then
            v = int'($urandom_range(40000)) - 20000;
            for (int i = 0; i < COL; i++) begin
                if ($urandom_range(7) == 0) begin
                    stim_row[i] = attn_pkg::score_t'(int'($urandom_range(65535)) - 32768);
                end else begin
                    stim_row[i] = attn_pkg::score_t'(v + int'($urandom_range(31)));
                end
            end
            send_row(1'b1);
        end
        wait_tiles(base + 20 * TPR, 20 * TPR * 20);
        compare_outputs("random_rows");
    endtask

    initial begin
        void'($urandom(17910));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_tile  = '0;
        reset_sequence();
        known_row();
        row_order();
        backpressure();
        credit_return();
        random_rows();
        repeat (5) step();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
